//--- sim.f
hw/pcie_tgt_pkg.sv
hw/cpl_req_if.sv
hw/fifo_wr_if.sv
hw/rx_req_ctrl.sv
hw/mem_rd_seq.sv
hw/cpl_fifo.sv
hw/cpl_tx.sv
hw/pcie_tgt_top.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# build the pcie target testbench with verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f sim.f -o tb_top_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_top_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
   exit 1
fi
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi
exit 0

//--- dv/tb_top.sv
// testbench: clock and reset, stimulus table, host link and memory models, result checks
`default_nettype none

module tb_top;

   localparam int          MEM_AW = 10;
   localparam int          TMO    = 500;              // cycles allowed for any one wait
   localparam int          K_WR   = 0;
   localparam int          K_RD   = 1;
   localparam int          K_MSG  = 2;
   localparam logic [12:0] BUSDEV = 13'h0A5;

   // dut inputs, all start inactive
   logic rstn = 1'b0;
   logic rx_req = 1'b0, rx_dv = 1'b0, rx_dfr = 1'b0;
   logic tx_sel = 1'b0, tx_ack = 1'b0, tx_ws = 1'b0, mem_rd_data_valid = 1'b0;
   pcie_tgt_pkg::tlp_hdr_t rx_desc = '0;
   pcie_tgt_pkg::data_t    rx_data = '0, mem_rd_data = '0;
   pcie_tgt_pkg::be_t      rx_be = '0;
   logic                   clk_in = 1'b0;
   // dut outputs
   logic                   rx_ack, tx_ready, tx_req, tx_dv, tx_dfr, tx_busy;
   logic                   mem_wr_ena, mem_rd_ena;
   pcie_tgt_pkg::tlp_hdr_t tx_desc;
   pcie_tgt_pkg::data_t    tx_data, mem_wr_data;
   pcie_tgt_pkg::be_t      mem_wr_be;
   logic [MEM_AW-1:0]      mem_wr_addr, mem_rd_addr;

   // stimulus table, one queue per column
   string       names[$];
   int          kinds[$];
   logic [31:0] addrs[$];
   logic [9:0]  lens[$];
   int          words[$];                             // expected 64-bit beats
   bit          stalls[$];                            // ws, late tx_sel, rx_dv gaps

   pcie_tgt_pkg::data_t mem_model [int unsigned];     // sparse local memory
   logic [MEM_AW+71:0]  wr_exp_q[$];                  // {addr, data, be} per payload beat
   logic [MEM_AW-1:0]   rd_addr_q[$];
   int unsigned         rd_due_q[$];                  // cycle when read data comes back
   int unsigned         cyc = 0;
   int unsigned         last_due = 0;
   int unsigned         rd_issued = 0;
   int unsigned         ack_cnt = 0;
   bit                  rd_active = 1'b0;
   string               cur_name = "reset";

   always #20 clk_in = ~clk_in;

   pcie_tgt_top #(.MEM_AW(MEM_AW), .FIFO_AW(4), .FIFO_AFULL(10)) i_dut (
      .clk_in, .rstn, .cfg_busdev (BUSDEV),
      .rx_req, .rx_desc, .rx_data, .rx_be, .rx_dv, .rx_dfr, .rx_ack,
      .tx_sel, .tx_ack, .tx_ws, .tx_ready, .tx_req, .tx_desc, .tx_data, .tx_dv, .tx_dfr,
      .tx_busy, .mem_wr_ena, .mem_wr_addr, .mem_wr_data, .mem_wr_be,
      .mem_rd_ena, .mem_rd_addr, .mem_rd_data, .mem_rd_data_valid
   );

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and checks
   ////////////////////////////////////////////////////////////////////////////
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_eq(input string what, input logic [127:0] exp, input logic [127:0] act);
      if (act !== exp)
         abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", what, exp, act));
   endtask

   task automatic add_entry(input string nm, input int kind, input logic [31:0] addr,
                            input logic [9:0] len, input int nw, input bit stall);
      names.push_back(nm);
      kinds.push_back(kind);
      addrs.push_back(addr);
      lens.push_back(len);
      words.push_back(nw);
      stalls.push_back(stall);
   endtask

   // unwritten words read back a pattern built from the whole address
   function automatic pcie_tgt_pkg::data_t mem_word(input logic [MEM_AW-1:0] a);
      if (mem_model.exists(a))
         return mem_model[a];
      return {6'h2A, a, 16'hBEEF, ~a, 6'h15, 16'h5A00};
   endfunction

   task automatic mem_store(input logic [MEM_AW-1:0] a, input pcie_tgt_pkg::data_t d,
                            input pcie_tgt_pkg::be_t be);
      pcie_tgt_pkg::data_t w;
      w = mem_word(a);
      for (int b = 0; b < 8; b++) begin
         if (be[b]) w[8*b +: 8] = d[8*b +: 8];    // byte lanes merge
      end
      mem_model[a] = w;
   endtask

   // 3dw request header, first/last dw byte enables all on
   function automatic pcie_tgt_pkg::tlp_hdr_t req_hdr(input int kind, input logic [31:0] addr,
                                                       input logic [9:0] len, input int idx);
      logic [1:0] fmt;
      logic [4:0] typ;
      fmt = (kind == K_RD) ? 2'b00 : ((kind == K_WR) ? 2'b10 : 2'b11);
      typ = (kind == K_MSG) ? 5'b10000 : 5'b00000;   // msgd routed to root
      return {1'b0, fmt, typ, 14'h0, len, 16'hA000 + 16'(idx), 8'h10 + 8'(idx), 8'hFF,
              addr, 32'h0};
   endfunction

   // cpld: completer function 0, successful, byte count four per dword
   function automatic pcie_tgt_pkg::tlp_hdr_t cpl_hdr(input logic [31:0] addr,
                                                       input logic [9:0] len, input int idx);
      return {1'b0, 2'b10, 5'b01010, 14'h0, len,
              BUSDEV, 3'b000, 3'b000, 1'b0, len, 2'b00,
              16'hA000 + 16'(idx), 8'h10 + 8'(idx), 1'b0, addr[6:0], 32'h0};
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // memory model and link monitors, all sampled on the falling edge
   ////////////////////////////////////////////////////////////////////////////
   always @(negedge clk_in) begin : mem_side
      int unsigned       due;
      logic [MEM_AW-1:0] ea;
      logic [63:0]       ed;
      logic [7:0]        eb;
      cyc = cyc + 1;
      mem_rd_data_valid = 1'b0;
      if (rd_due_q.size() != 0 && rd_due_q[0] <= cyc) begin   // in order, one per cycle
         mem_rd_data_valid = 1'b1;
         mem_rd_data       = mem_word(rd_addr_q.pop_front());
         void'(rd_due_q.pop_front());
      end
      if (rstn && mem_rd_ena) begin
         if (!rd_active) abort_run("memory read issued while no read request was open");
         due = cyc + 1 + $urandom_range(3);                  // latency 1..4
         if (due <= last_due) due = last_due + 1;
         last_due = due;
         rd_addr_q.push_back(mem_rd_addr);
         rd_due_q.push_back(due);
         rd_issued++;
      end
      if (rstn && mem_wr_ena) begin
         if (wr_exp_q.size() == 0) begin
            abort_run("memory write seen with no write payload outstanding");
         end else begin
            {ea, ed, eb} = wr_exp_q.pop_front();
            check_eq({cur_name, " mem_wr_addr"}, ea, mem_wr_addr);
            check_eq({cur_name, " mem_wr_data"}, ed, mem_wr_data);
            check_eq({cur_name, " mem_wr_be"}, eb, mem_wr_be);
            mem_store(mem_wr_addr, mem_wr_data, mem_wr_be);
         end
      end
   end

   always @(negedge clk_in) begin
      if (rstn && rx_ack) ack_cnt++;                          // a long pulse counts twice
      if (rstn && !rd_active && (tx_ready || tx_req || tx_dv || tx_busy))
         abort_run("completion link went active while no read request was open");
   end

   ////////////////////////////////////////////////////////////////////////////
   // request link driver
   ////////////////////////////////////////////////////////////////////////////
   task automatic send_req(input pcie_tgt_pkg::tlp_hdr_t hdr);
      @(negedge clk_in);
      rx_req  = 1'b1;
      rx_desc = hdr;
      @(negedge clk_in);
      check_eq({cur_name, " rx_ack one cycle after rx_req"}, 1, rx_ack);
      rx_req  = 1'b0;
      rx_desc = '0;
   endtask

   // payload beats from the ack cycle on, rx_dfr low on the last one
   task automatic send_beats(input logic [31:0] addr, input int n, input bit gaps,
                             input bit expect_wr);
      logic [MEM_AW-1:0]   wa;
      pcie_tgt_pkg::data_t d;
      pcie_tgt_pkg::be_t   b;
      int                  k;
      wa = addr[MEM_AW+2:3];
      k  = 0;
      while (k < n) begin
         if (gaps && $urandom_range(2) == 0) begin
            rx_dv  = 1'b0;                               // idle beat inside the payload
            rx_dfr = 1'b1;
         end else begin
            d = {$urandom, $urandom};
            b = 8'($urandom);
            rx_dv   = 1'b1;
            rx_data = d;
            rx_be   = b;
            rx_dfr  = (k != n - 1);
            if (expect_wr) wr_exp_q.push_back({wa, d, b});
            wa++;
            k++;
         end
         @(negedge clk_in);
      end
      rx_dv  = 1'b0;
      rx_dfr = 1'b0;
   endtask

   task automatic run_write(input int idx);
      int t;
      send_req(req_hdr(K_WR, addrs[idx], lens[idx], idx));
      send_beats(addrs[idx], words[idx], stalls[idx], 1'b1);
      t = 0;
      while (wr_exp_q.size() != 0) begin
         @(negedge clk_in);
         t++;
         if (t > TMO) abort_run({cur_name, ": timed out waiting for the memory writes"});
      end
   endtask

   task automatic run_msg(input int idx);
      send_req(req_hdr(K_MSG, addrs[idx], lens[idx], idx));
      send_beats(addrs[idx], words[idx], 1'b0, 1'b0);
      repeat (6) @(negedge clk_in);                      // window for a stray write or cpld
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // read: arbitration, header check, counted beats against the memory model
   ////////////////////////////////////////////////////////////////////////////
   task automatic run_read(input int idx);
      logic [MEM_AW-1:0] base;
      logic [31:0]       a;
      int                n;
      int                beats;
      int                t;
      bit                ws;
      a         = addrs[idx];
      n         = words[idx];
      base      = a[MEM_AW+2:3];
      rd_issued = 0;
      rd_active = 1'b1;
      send_req(req_hdr(K_RD, a, lens[idx], idx));
      t = 0;
      while (!tx_ready) begin
         @(negedge clk_in);
         t++;
         if (t > TMO) abort_run({cur_name, ": timed out waiting for tx_ready"});
      end
      if (stalls[idx]) repeat ($urandom_range(6, 1)) @(negedge clk_in);   // late grant
      tx_sel = 1'b1;
      t = 0;
      while (!tx_req) begin
         @(negedge clk_in);
         t++;
         if (t > TMO) abort_run({cur_name, ": timed out waiting for tx_req after tx_sel"});
      end
      tx_sel = 1'b0;
      tx_ack = 1'b1;
      check_eq({cur_name, " cpld header"}, cpl_hdr(a, lens[idx], idx), tx_desc);
      beats = 0;
      t     = 0;
      while (beats < n) begin
         @(negedge clk_in);
         tx_ack = 1'b0;
         ws     = stalls[idx] && ($urandom_range(2) == 0);
         tx_ws  = ws;                                    // this cycle's beat counts only if low
         if (tx_dv && !ws) begin
            check_eq({cur_name, $sformatf(" beat %0d data", beats)},
                     mem_word(base + MEM_AW'(beats)), tx_data);
            check_eq({cur_name, $sformatf(" beat %0d tx_dfr", beats)}, beats != n - 1, tx_dfr);
            beats++;
         end
         t++;
         if (t > TMO) abort_run({cur_name, ": timed out waiting for completion data beats"});
      end
      tx_ws = 1'b0;
      t     = 0;
      while (tx_busy) begin
         @(negedge clk_in);
         t++;
         if (t > TMO) abort_run({cur_name, ": timed out waiting for tx_busy to drop"});
      end
      rd_active = 1'b0;
      check_eq({cur_name, " memory reads issued"}, n, rd_issued);
      check_eq({cur_name, " reads left unanswered"}, 0, rd_due_q.size());
   endtask

   initial begin : main
      void'($urandom(70582));                            // single seed for the whole run
      add_entry("wr_aligned",   K_WR,  32'h0000_0100, 10'd6,  3,  1'b0);
      add_entry("rd_back",      K_RD,  32'h0000_0100, 10'd6,  3,  1'b0);
      add_entry("rd_fill_odd",  K_RD,  32'h0000_0204, 10'd5,  3,  1'b0);
      add_entry("msg_drop",     K_MSG, 32'h0000_0000, 10'd2,  1,  1'b0);
      add_entry("wr_unaligned", K_WR,  32'h0000_030C, 10'd3,  2,  1'b1);
      add_entry("rd_unaligned", K_RD,  32'h0000_030C, 10'd4,  3,  1'b1);
      add_entry("rd_long",      K_RD,  32'h0000_0400, 10'd48, 24, 1'b1);   // beyond fifo depth
      add_entry("rd_single",    K_RD,  32'h0000_00FC, 10'd1,  1,  1'b0);
      repeat (3) @(posedge clk_in);
      @(negedge clk_in);
      check_eq("reset outputs", 0,
               {rx_ack, mem_wr_ena, mem_rd_ena, tx_ready, tx_req, tx_dv, tx_dfr, tx_busy});
      rstn = 1'b1;
      for (int i = 0; i < names.size(); i++) begin
         cur_name = names[i];
         case (kinds[i])
            K_WR:    run_write(i);
            K_RD:    run_read(i);
            default: run_msg(i);
         endcase
         repeat (2) @(negedge clk_in);                   // request fsm back in idle
         check_eq({cur_name, " rx_ack pulses so far"}, i + 1, ack_cnt);
      end
      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- hw/pcie_tgt_top.sv
// pcie downstream target top level: request controller, read sequencer, fifo, cpld transmitter
`default_nettype none

module pcie_tgt_top #(
   parameter int MEM_AW     = 10,       // local memory word address width
   parameter int FIFO_AW    = 4,        // log2 fifo depth
   parameter int FIFO_AFULL = 10        // almost-full threshold
) (
   input  wire                          clk_in,
   input  wire                          rstn,
   input  wire pcie_tgt_pkg::busdev_t   cfg_busdev,
   // request link
   input  wire                          rx_req,
   input  wire pcie_tgt_pkg::tlp_hdr_t  rx_desc,
   input  wire pcie_tgt_pkg::data_t     rx_data,
   input  wire pcie_tgt_pkg::be_t       rx_be,
   input  wire                          rx_dv,
   input  wire                          rx_dfr,
   output logic                         rx_ack,
   // completion link
   input  wire                          tx_sel,
   input  wire                          tx_ack,
   input  wire                          tx_ws,
   output logic                         tx_ready,
   output logic                         tx_req,
   output pcie_tgt_pkg::tlp_hdr_t       tx_desc,
   output pcie_tgt_pkg::data_t          tx_data,
   output logic                         tx_dv,
   output logic                         tx_dfr,
   output logic                         tx_busy,
   // local memory
   output logic                         mem_wr_ena,
   output logic [MEM_AW-1:0]            mem_wr_addr,
   output pcie_tgt_pkg::data_t          mem_wr_data,
   output pcie_tgt_pkg::be_t            mem_wr_be,
   output logic                         mem_rd_ena,
   output logic [MEM_AW-1:0]            mem_rd_addr,
   input  wire pcie_tgt_pkg::data_t     mem_rd_data,
   input  wire                          mem_rd_data_valid
);

   cpl_req_if #(.MEM_AW(MEM_AW)) cpl ();   // read request to seq and tx
   fifo_wr_if fwr ();                      // seq -> fifo

   logic                fifo_rd;
   pcie_tgt_pkg::data_t fifo_q;
   logic                fifo_empty;

   rx_req_ctrl #(.MEM_AW(MEM_AW)) i_rx_ctrl (
      .clk_in, .rstn,
      .rx_req, .rx_desc, .rx_data, .rx_be, .rx_dv, .rx_dfr, .rx_ack,
      .mem_wr_ena, .mem_wr_addr, .mem_wr_data, .mem_wr_be,
      .cpl (cpl)
   );

   mem_rd_seq #(.MEM_AW(MEM_AW)) i_rd_seq (
      .clk_in, .rstn,
      .cpl (cpl),
      .mem_rd_ena, .mem_rd_addr, .mem_rd_data, .mem_rd_data_valid,
      .fifo (fwr)
   );

   cpl_fifo #(.FIFO_AW(FIFO_AW), .FIFO_AFULL(FIFO_AFULL)) i_cpl_fifo (
      .clk_in, .rstn,
      .wr_if (fwr),
      .rd    (fifo_rd),
      .q     (fifo_q),
      .empty (fifo_empty)
   );

   cpl_tx i_cpl_tx (
      .clk_in, .rstn,
      .cpl   (cpl),
      .q     (fifo_q),
      .empty (fifo_empty),
      .cfg_busdev, .tx_sel, .tx_ack, .tx_ws,
      .rd    (fifo_rd),
      .tx_ready, .tx_req, .tx_desc, .tx_data, .tx_dv, .tx_dfr, .tx_busy
   );

endmodule

`default_nettype wire

//--- hw/cpl_tx.sv
// completion transmitter: link arbitration, cpld header build, data streaming with wait states
`default_nettype none

module cpl_tx (
   input  wire                         clk_in,
   input  wire                         rstn,
   cpl_req_if.tx                       cpl,
   input  wire pcie_tgt_pkg::data_t    q,
   input  wire                         empty,
   input  wire pcie_tgt_pkg::busdev_t  cfg_busdev,
   input  wire                         tx_sel,
   input  wire                         tx_ack,
   input  wire                         tx_ws,
   output logic                        rd,
   output logic                        tx_ready,
   output logic                        tx_req,
   output pcie_tgt_pkg::tlp_hdr_t      tx_desc,
   output pcie_tgt_pkg::data_t         tx_data,
   output logic                        tx_dv,
   output logic                        tx_dfr,
   output logic                        tx_busy
);

   pcie_tgt_pkg::tx_state_t state;
   pcie_tgt_pkg::word_cnt_t rd_cnt;         // words pulled from the fifo
   pcie_tgt_pkg::word_cnt_t beat_cnt;       // beats accepted by the link
   pcie_tgt_pkg::word_cnt_t presented;      // accepted plus the one on the bus
   logic                    grant;
   logic                    beat;

   assign grant     = (state == pcie_tgt_pkg::TX_IDLE) & tx_ready & tx_sel & ~empty;
   assign beat      = tx_dv & ~tx_ws;       // counted beat
   assign presented = beat_cnt + pcie_tgt_pkg::word_cnt_t'(tx_dv);

   // fetch the next word when the bus slot frees up, a ws stall holds it
   assign rd = (state != pcie_tgt_pkg::TX_IDLE) & (~tx_dv | beat) &
               (rd_cnt != cpl.n_words) & ~empty;

   assign tx_data = q;
   assign tx_dfr  = tx_busy & (presented < cpl.n_words);   // low on the last beat

   ////////////////////////////////////////////////////////////////////////////
   // cpld header, successful status, completer function 0
   ////////////////////////////////////////////////////////////////////////////
   assign tx_desc = {1'b0, pcie_tgt_pkg::FMT_TYPE_CPLD, 14'h0, cpl.length,
                     cfg_busdev, 3'b000,                   // completer id
                     4'h0, cpl.length, 2'b00,              // status, byte count
                     cpl.req_id, cpl.tag, 1'b0, cpl.low_addr, 32'h0};

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         state    <= pcie_tgt_pkg::TX_IDLE;
         tx_ready <= 1'b0;
         tx_req   <= 1'b0;
         tx_dv    <= 1'b0;
         tx_busy  <= 1'b0;
         rd_cnt   <= '0;
         beat_cnt <= '0;
         cpl.done <= 1'b0;
      end else begin
         cpl.done <= 1'b0;
         tx_dv    <= rd | (tx_dv & tx_ws);  // new word, or hold a stalled one
         if (rd)   rd_cnt   <= rd_cnt + 1'b1;
         if (beat) beat_cnt <= beat_cnt + 1'b1;
         case (state)
            pcie_tgt_pkg::TX_IDLE: begin
               if (cpl.start) tx_ready <= 1'b1;   // ask the arbiter for the link
               if (grant) begin                   // granted and data waiting
                  tx_ready <= 1'b0;
                  tx_req   <= 1'b1;
                  tx_busy  <= 1'b1;
                  rd_cnt   <= '0;
                  beat_cnt <= '0;
                  state    <= pcie_tgt_pkg::TX_SEND_REQ;
               end
            end
            pcie_tgt_pkg::TX_SEND_REQ: begin
               if (tx_ack) begin
                  tx_req <= 1'b0;
                  state  <= pcie_tgt_pkg::TX_PAYLOAD;
               end
            end
            pcie_tgt_pkg::TX_PAYLOAD: begin
               if (beat_cnt == cpl.n_words) begin // all beats taken
                  tx_busy  <= 1'b0;
                  cpl.done <= 1'b1;
                  state    <= pcie_tgt_pkg::TX_IDLE;
               end
            end
            default: state <= pcie_tgt_pkg::TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hw/cpl_fifo.sv
// rate-matching fifo between memory read data and the completion link
`default_nettype none

module cpl_fifo #(
   parameter int FIFO_AW    = 4,
   parameter int FIFO_AFULL = 10
) (
   input  wire                 clk_in,
   input  wire                 rstn,
   fifo_wr_if.dst              wr_if,
   input  wire                 rd,
   output pcie_tgt_pkg::data_t q,          // valid the cycle after rd
   output logic                empty
);

   pcie_tgt_pkg::data_t mem [2**FIFO_AW];
   logic [FIFO_AW-1:0]  wr_ptr;
   logic [FIFO_AW-1:0]  rd_ptr;
   logic [FIFO_AW:0]    count;              // fill level, 0 .. depth
   logic                rd_ok;

   assign rd_ok             = rd & ~empty;  // underflow reads are dropped
   assign empty             = (count == '0);
   assign wr_if.almost_full = (count >= (FIFO_AW+1)'(FIFO_AFULL));

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr_if.wr) wr_ptr <= wr_ptr + 1'b1;
         if (rd_ok)    rd_ptr <= rd_ptr + 1'b1;
         case ({wr_if.wr, rd_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;        // both or neither
         endcase
      end
   end

   // storage and registered read port
   always_ff @(posedge clk_in) begin
      if (wr_if.wr) mem[wr_ptr] <= wr_if.data;
      if (rd_ok)    q <= mem[rd_ptr];
   end

endmodule

`default_nettype wire

//--- hw/mem_rd_seq.sv
// memory read sequencer: issues reads for a completion and pushes returned data into the fifo
`default_nettype none

module mem_rd_seq #(
   parameter int MEM_AW = 10
) (
   input  wire                      clk_in,
   input  wire                      rstn,
   cpl_req_if.seq                   cpl,
   output logic                     mem_rd_ena,
   output logic [MEM_AW-1:0]        mem_rd_addr,
   input  wire pcie_tgt_pkg::data_t mem_rd_data,
   input  wire                      mem_rd_data_valid,
   fifo_wr_if.src                   fifo
);

   pcie_tgt_pkg::word_cnt_t words_left;   // reads still to issue after the first
   logic                    issue;

   // one read per cycle, paused while the fifo is nearly full
   assign issue = (words_left != '0) & ~fifo.almost_full;

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         mem_rd_ena <= 1'b0;
         words_left <= '0;
         fifo.wr    <= 1'b0;
      end else begin
         if (cpl.start) begin
            mem_rd_ena <= 1'b1;             // first read right after start
            words_left <= cpl.n_words - 1'b1;
         end else if (issue) begin
            mem_rd_ena <= 1'b1;
            words_left <= words_left - 1'b1;
         end else begin
            mem_rd_ena <= 1'b0;
         end
         fifo.wr <= mem_rd_data_valid;      // returned data lands in order
      end
   end

   always_ff @(posedge clk_in) begin
      if (cpl.start)  mem_rd_addr <= cpl.mem_addr;
      else if (issue) mem_rd_addr <= mem_rd_addr + 1'b1;
      fifo.data <= mem_rd_data;
   end

endmodule

`default_nettype wire

//--- hw/rx_req_ctrl.sv
// request controller: tlp decode and ack, memory write pipeline, read request latch
`default_nettype none

module rx_req_ctrl #(
   parameter int MEM_AW = 10
) (
   input  wire                          clk_in,
   input  wire                          rstn,
   input  wire                          rx_req,
   input  wire pcie_tgt_pkg::tlp_hdr_t  rx_desc,
   input  wire pcie_tgt_pkg::data_t     rx_data,
   input  wire pcie_tgt_pkg::be_t       rx_be,
   input  wire                          rx_dv,
   input  wire                          rx_dfr,
   output logic                         rx_ack,
   output logic                         mem_wr_ena,
   output logic [MEM_AW-1:0]            mem_wr_addr,
   output pcie_tgt_pkg::data_t          mem_wr_data,
   output pcie_tgt_pkg::be_t            mem_wr_be,
   cpl_req_if.ctrl                      cpl
);

   pcie_tgt_pkg::rx_state_t state;
   logic [31:0]             addr3;          // address dword of the header
   logic                    is_rd_n;        // decode of the current descriptor
   logic                    is_wr_n;
   logic                    is_msg_n;
   logic                    accept;
   logic                    is_rd;          // class of the accepted request
   logic                    is_wr;
   logic                    wr_beat;
   logic [MEM_AW-1:0]       addr_q;         // word address, steps per write beat
   pcie_tgt_pkg::word_cnt_t n_words_calc;

   ////////////////////////////////////////////////////////////////////////////
   // descriptor decode
   ////////////////////////////////////////////////////////////////////////////
   assign addr3    = rx_desc[pcie_tgt_pkg::HDR_ADDR3_MSB:pcie_tgt_pkg::HDR_ADDR3_LSB];
   assign is_rd_n  = ~rx_desc[pcie_tgt_pkg::HDR_FMT_WR_BIT] &
                     (rx_desc[pcie_tgt_pkg::HDR_TYPE_MSB:pcie_tgt_pkg::HDR_TYPE_LSB]
                      == pcie_tgt_pkg::TYPE_MEM);
   assign is_wr_n  = rx_desc[pcie_tgt_pkg::HDR_FMT_WR_BIT] &
                     (rx_desc[pcie_tgt_pkg::HDR_TYPE_MSB:pcie_tgt_pkg::HDR_TYPE_LSB]
                      == pcie_tgt_pkg::TYPE_MEM);
   assign is_msg_n = (rx_desc[pcie_tgt_pkg::HDR_MSG_MSB:pcie_tgt_pkg::HDR_MSG_LSB]
                      == pcie_tgt_pkg::FMT_MSG_BITS);
   assign accept   = (state == pcie_tgt_pkg::RX_IDLE) & rx_req & (is_rd_n | is_wr_n | is_msg_n);

   // words spanned: dw offset inside the first 64-bit word plus length, rounded up
   assign n_words_calc = ({1'b0, rx_desc[pcie_tgt_pkg::HDR_LEN_MSB:pcie_tgt_pkg::HDR_LEN_LSB]}
                          + {10'd0, addr3[2]} + 11'd1) >> 1;

   // payload beats only count for a write, from the ack cycle on
   assign wr_beat = is_wr & rx_dv &
                    ((state == pcie_tgt_pkg::RX_DESC2) | (state == pcie_tgt_pkg::RX_PAYLOAD));

   assign cpl.mem_addr = addr_q;            // stable while a read is in flight

   always_ff @(posedge clk_in or negedge rstn) begin
      if (!rstn) begin
         state      <= pcie_tgt_pkg::RX_IDLE;
         rx_ack     <= 1'b0;
         is_rd      <= 1'b0;
         is_wr      <= 1'b0;
         cpl.start  <= 1'b0;
         mem_wr_ena <= 1'b0;
      end else begin
         rx_ack     <= 1'b0;                // single-cycle pulses
         cpl.start  <= 1'b0;
         mem_wr_ena <= wr_beat;             // one write per beat, a cycle later
         case (state)
            pcie_tgt_pkg::RX_IDLE: begin
               if (accept) begin
                  rx_ack <= 1'b1;
                  is_rd  <= is_rd_n;
                  is_wr  <= is_wr_n;        // messages leave both low
                  state  <= pcie_tgt_pkg::RX_DESC2;
               end
            end
            pcie_tgt_pkg::RX_DESC2: begin
               if (is_rd) begin
                  cpl.start <= 1'b1;        // kick sequencer and transmitter
                  state     <= pcie_tgt_pkg::RX_WAIT_CPL;
               end else if (rx_dfr) begin
                  state <= pcie_tgt_pkg::RX_PAYLOAD;
               end else begin
                  state <= pcie_tgt_pkg::RX_IDLE;
               end
            end
            pcie_tgt_pkg::RX_PAYLOAD: begin
               if (!rx_dfr) state <= pcie_tgt_pkg::RX_IDLE;
            end
            pcie_tgt_pkg::RX_WAIT_CPL: begin
               if (cpl.done) state <= pcie_tgt_pkg::RX_IDLE;   // no new request before this
            end
            default: state <= pcie_tgt_pkg::RX_IDLE;
         endcase
      end
   end

   // request fields and write datapath
   always_ff @(posedge clk_in) begin
      if (accept) begin
         addr_q       <= addr3[MEM_AW+2:3];
         cpl.length   <= rx_desc[pcie_tgt_pkg::HDR_LEN_MSB:pcie_tgt_pkg::HDR_LEN_LSB];
         cpl.tag      <= rx_desc[pcie_tgt_pkg::HDR_TAG_MSB:pcie_tgt_pkg::HDR_TAG_LSB];
         cpl.req_id   <= rx_desc[pcie_tgt_pkg::HDR_REQID_MSB:pcie_tgt_pkg::HDR_REQID_LSB];
         cpl.low_addr <= addr3[6:0];
         cpl.n_words  <= n_words_calc;
      end else if (wr_beat) begin
         addr_q <= addr_q + 1'b1;
      end
      mem_wr_addr <= addr_q;
      mem_wr_data <= rx_data;
      mem_wr_be   <= rx_be;
   end

endmodule

`default_nettype wire

//--- hw/fifo_wr_if.sv
// write side of the completion rate-matching fifo
`default_nettype none

interface fifo_wr_if ();
   logic                wr;             // push data this cycle
   pcie_tgt_pkg::data_t data;
   logic                almost_full;    // back-pressure to the read sequencer

   modport src (output wr, data, input almost_full);
   modport dst (input wr, data, output almost_full);
endinterface

`default_nettype wire

//--- hw/cpl_req_if.sv
// latched read request passed from the request controller to the sequencer and transmitter
`default_nettype none

interface cpl_req_if #(
   parameter int MEM_AW = 10
) ();
   logic                    start;      // one-cycle pulse, fields below are stable
   logic [MEM_AW-1:0]       mem_addr;   // first memory word of the read
   pcie_tgt_pkg::word_cnt_t n_words;    // 64-bit words to fetch and send
   pcie_tgt_pkg::dw_len_t   length;
   pcie_tgt_pkg::tag_t      tag;
   pcie_tgt_pkg::req_id_t   req_id;
   pcie_tgt_pkg::low_addr_t low_addr;
   logic                    done;       // pulse after the last completion beat

   modport ctrl (output start, mem_addr, n_words, length, tag, req_id, low_addr, input done);
   modport seq  (input start, mem_addr, n_words);
   modport tx   (input start, n_words, length, tag, req_id, low_addr, output done);
endinterface

`default_nettype wire

//--- hw/pcie_tgt_pkg.sv
// tlp field types, header bit positions, encodings and fsm state enums for the pcie target
`default_nettype none

package pcie_tgt_pkg;

   localparam int DATA_W = 64;                        // transaction-layer datapath width

   typedef logic [127:0]        tlp_hdr_t;            // rx_desc / tx_desc descriptor
   typedef logic [DATA_W-1:0]   data_t;               // one data beat
   typedef logic [DATA_W/8-1:0] be_t;                 // byte enables of a beat
   typedef logic [9:0]          dw_len_t;             // tlp length in dwords
   typedef logic [7:0]          tag_t;
   typedef logic [15:0]         req_id_t;
   typedef logic [12:0]         busdev_t;             // bus and device number
   typedef logic [6:0]          low_addr_t;           // completion lower address
   typedef logic [10:0]         word_cnt_t;           // count of 64-bit memory words

   // encodings
   localparam logic [4:0] TYPE_MEM      = 5'b00000;   // memory request type
   localparam logic [2:0] FMT_MSG_BITS  = 3'b110;     // fmt/type bits of a message
   localparam logic [6:0] FMT_TYPE_CPLD = 7'h4A;      // completion with data

   ////////////////////////////////////////////////////////////////////////////
   // 3dw header bit positions inside the 128-bit descriptor
   ////////////////////////////////////////////////////////////////////////////
   localparam int HDR_FMT_WR_BIT = 126;               // 1: request carries data
   localparam int HDR_MSG_MSB    = 125;
   localparam int HDR_MSG_LSB    = 123;
   localparam int HDR_TYPE_MSB   = 124;
   localparam int HDR_TYPE_LSB   = 120;
   localparam int HDR_LEN_MSB    = 105;
   localparam int HDR_LEN_LSB    = 96;
   localparam int HDR_REQID_MSB  = 95;
   localparam int HDR_REQID_LSB  = 80;
   localparam int HDR_TAG_MSB    = 79;
   localparam int HDR_TAG_LSB    = 72;
   localparam int HDR_ADDR3_MSB  = 63;                // address dword of a 3dw header
   localparam int HDR_ADDR3_LSB  = 32;

   typedef enum logic [1:0] {
      RX_IDLE,                                        // wait for rx_req
      RX_DESC2,                                       // ack cycle, classify
      RX_PAYLOAD,                                     // payload beats until rx_dfr low
      RX_WAIT_CPL                                     // read in flight, wait for done
   } rx_state_t;

   typedef enum logic [1:0] {
      TX_IDLE,                                        // tx_ready up, wait for grant
      TX_SEND_REQ,                                    // tx_req held until tx_ack
      TX_PAYLOAD                                      // remaining data beats
   } tx_state_t;

endpackage

`default_nettype wire
